// File: hdl/vaddr_cfg_pkg.sv
// Address width, data path width, page size, burst limit and queue depth constants
package vaddr_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Address space
  ////////////////////////////////////////////////////////////

  // Physical address width
  localparam int unsigned AddrWidth = 32;
  // Offset bits inside one 4 KiB page
  localparam int unsigned PageBits = 12;

  ////////////////////////////////////////////////////////////
  // Data path and bursts
  ////////////////////////////////////////////////////////////

  // 64-bit data path
  localparam int unsigned DataBytes = 8;
  localparam int unsigned DataBytesLog = 3;
  // Longest incrementing burst in beats
  localparam int unsigned MaxBurstBeats = 256;

  ////////////////////////////////////////////////////////////
  // Instruction side and command queue
  ////////////////////////////////////////////////////////////

  // Width of the element count of one instruction
  localparam int unsigned LenWidth = 16;
  // Entries of the queue toward the load/store units
  localparam int unsigned CmdQueueDepth = 4;

endpackage

// File: hdl/vaddr_types_pkg.sv
// Address and length types, element width and operation enums, address command struct
package vaddr_types_pkg;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////

  // Byte address
  typedef logic [vaddr_cfg_pkg::AddrWidth-1:0] addr_t;
  // Number of elements of one instruction
  typedef logic [vaddr_cfg_pkg::LenWidth-1:0] len_t;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Element width, encoded as log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector memory operation
  // VLE/VSE are unit-stride, VLSE/VSSE are strided
  typedef enum logic [1:0] {
    VLE  = 2'd0,
    VSE  = 2'd1,
    VLSE = 2'd2,
    VSSE = 2'd3
  } vmem_op_e;

  ////////////////////////////////////////////////////////////
  // Command toward the load/store units
  ////////////////////////////////////////////////////////////

  // One issued AR or AW request as seen by the load/store units
  typedef struct packed {
    // Start address of the request
    addr_t                                           addr;
    // Beat count minus one
    logic [$clog2(vaddr_cfg_pkg::MaxBurstBeats)-1:0] len;
    // Log2 of bytes per beat
    logic [2:0]                                      size;
    // Set for AR, clear for AW
    logic                                            is_load;
  } ax_cmd_t;

endpackage

// File: hdl/vaddr_req_if.sv
// Request interface from instruction acceptance to burst splitting, with its modports
`timescale 1ns/100ps

interface vaddr_req_if;
  import vaddr_types_pkg::*;

  // Handshake
  // valid holds with stable fields until ready
  logic  valid;
  // One-cycle pulse once the last request of the operation is issued
  logic  ready;

  // Request fields
  addr_t addr;
  len_t  len;
  addr_t stride;
  vew_e  vew;
  // Read channel when set
  logic  is_load;
  // Unit-stride operation, cut into incrementing bursts
  logic  is_burst;

  // Acceptance side
  modport accept (
    output valid, addr, len, stride, vew, is_load, is_burst,
    input  ready
  );

  // Splitting side
  modport split (
    input  valid, addr, len, stride, vew, is_load, is_burst,
    output ready
  );

endinterface

// File: hdl/vinsn_accept.sv
// Vector memory instruction acceptance with alignment check and acknowledge
`timescale 1ns/100ps

module vinsn_accept (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  input  vaddr_types_pkg::vmem_op_e req_op_i,
  input  vaddr_types_pkg::addr_t    req_addr_i,
  input  vaddr_types_pkg::len_t     req_len_i,
  input  vaddr_types_pkg::addr_t    req_stride_i,
  input  vaddr_types_pkg::vew_e     req_vew_i,
  output logic                      ack_o,
  output logic                      error_o,
  vaddr_req_if.accept               req
);
  import vaddr_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE
  } state_e;

  state_e   state_q, state_d;

  // Registered instruction
  vmem_op_e op_q;
  addr_t    addr_q;
  len_t     len_q;
  addr_t    stride_q;
  vew_e     vew_q;

  logic     misaligned;
  // Acknowledge one cycle after the splitter is done
  logic     ack_q;

  // Any set address bit below the element width
  function automatic logic is_misaligned(addr_t addr, vew_e vew);
    addr_t mask;
    mask = addr_t'((1 << vew) - 1);
    return |(addr & mask);
  endfunction

  assign misaligned = is_misaligned(addr_q, vew_q);

  ////////////////////////////////////////////////////////////
  // Request toward the splitter
  ////////////////////////////////////////////////////////////

  assign req.addr     = addr_q;
  assign req.len      = len_q;
  assign req.stride   = stride_q;
  assign req.vew      = vew_q;
  assign req.is_load  = (op_q == VLE) || (op_q == VLSE);
  assign req.is_burst = (op_q == VLE) || (op_q == VSE);

  // Valid from the check cycle on, if the base is aligned
  assign req.valid = ((state_q == CHECK) && !misaligned) || (state_q == ISSUE);

  // Error ack comes straight out of the check cycle
  assign error_o = (state_q == CHECK) && misaligned;
  assign ack_o   = error_o || ack_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) state_d = CHECK;
      end
      CHECK: begin
        if (misaligned || req.ready) state_d = IDLE;
        else state_d = ISSUE;
      end
      ISSUE: begin
        if (req.ready) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= req.valid && req.ready;
    end
  end

  // New instructions are only taken while idle
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      op_q     <= req_op_i;
      addr_q   <= req_addr_i;
      len_q    <= req_len_i;
      stride_q <= req_stride_i;
      vew_q    <= req_vew_i;
    end
  end

endmodule

// File: hdl/burst_splitter.sv
// Burst splitter FSM cutting requests into AR/AW bursts or strided single beats
`timescale 1ns/100ps

module burst_splitter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     st_pending_i,
  input  logic                     ar_ready_i,
  input  logic                     aw_ready_i,
  input  logic                     q_full_i,
  input  logic                     q_empty_i,
  input  logic                     q_head_is_load_i,
  output logic                     ar_valid_o,
  output logic                     aw_valid_o,
  output vaddr_types_pkg::ax_cmd_t ax_o,
  output logic                     push_o,
  vaddr_req_if.split               req
);
  import vaddr_cfg_pkg::*;
  import vaddr_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAITING,
    REQUESTING
  } state_e;

  state_e state_q, state_d;

  // Current request
  addr_t  addr_q;
  len_t   len_q;
  addr_t  stride_q;
  vew_e   vew_q;
  logic   is_load_q;
  logic   is_burst_q;

  // Bounds of the pending burst, all beat aligned except the end
  addr_t  start_q, end_q, next_q;

  // Bounds calculator inputs and results
  addr_t  calc_addr;
  len_t   calc_len;
  vew_e   calc_vew;
  addr_t  calc_bytes, calc_start, calc_last, calc_cap;
  addr_t  calc_end, calc_next;

  // Burst accounting
  logic [PageBits-1:0]              span_m1;
  logic [PageBits:0]                span_bytes;
  logic [PageBits:0]                consumed;
  len_t                             len_rem;
  logic [$clog2(MaxBurstBeats)-1:0] burst_len;

  logic   chan_ready, dir_ok, st_clear, issue, last_beat;

  // Clear the byte offset inside one beat
  function automatic addr_t align_beat(addr_t addr);
    return {addr[AddrWidth-1:DataBytesLog], {DataBytesLog{1'b0}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // Burst bounds
  ////////////////////////////////////////////////////////////

  // New request while idle, otherwise the burst after the current one
  assign calc_addr = (state_q == IDLE) ? req.addr : next_q;
  assign calc_len  = (state_q == IDLE) ? req.len  : len_rem;
  assign calc_vew  = (state_q == IDLE) ? req.vew  : vew_q;

  assign calc_bytes = addr_t'(calc_len) << calc_vew;
  assign calc_start = align_beat(calc_addr);
  // One past the beat holding the last data byte
  assign calc_last  = align_beat(calc_addr + calc_bytes - 1) + addr_t'(DataBytes);
  // One past the longest burst
  assign calc_cap   = calc_start + addr_t'(MaxBurstBeats * DataBytes);

  always_comb begin
    calc_next = ((calc_last - calc_start) > addr_t'(MaxBurstBeats * DataBytes)) ?
                calc_cap : calc_last;
    calc_end  = calc_next - 1;
    // Stop at the end of the 4 KiB page
    if (calc_end[AddrWidth-1:PageBits] != calc_start[AddrWidth-1:PageBits]) begin
      calc_end  = {calc_start[AddrWidth-1:PageBits], {PageBits{1'b1}}};
      calc_next = {calc_start[AddrWidth-1:PageBits] + 1'b1, {PageBits{1'b0}}};
    end
  end

  // Beats minus one of the pending burst
  assign span_m1   = end_q[PageBits-1:0] - start_q[PageBits-1:0];
  assign burst_len = span_m1[DataBytesLog +: $clog2(MaxBurstBeats)];

  // Elements covered from the current address to the burst end
  assign span_bytes = {1'b0, end_q[PageBits-1:0]} - {1'b0, addr_q[PageBits-1:0]} + 1'b1;
  assign consumed   = span_bytes >> vew_q;
  // Last burst may round up past the final element
  assign len_rem    = (len_q > len_t'(consumed)) ? len_q - len_t'(consumed) : '0;

  ////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////

  assign chan_ready = is_load_q ? ar_ready_i : aw_ready_i;
  // Keep responses in order across AR and AW
  assign dir_ok     = q_empty_i || (q_head_is_load_i == is_load_q);
  // Stores stay behind a pending scalar store
  assign st_clear   = is_load_q || !st_pending_i;
  assign issue      = (state_q == REQUESTING) && chan_ready && !q_full_i && dir_ok && st_clear;
  assign last_beat  = is_burst_q ? (len_rem == '0) : (len_q == len_t'(1));

  assign ar_valid_o = issue && is_load_q;
  assign aw_valid_o = issue && !is_load_q;
  assign push_o     = issue;

  always_comb begin
    ax_o.addr    = addr_q;
    ax_o.is_load = is_load_q;
    if (is_burst_q) begin
      // Full data path beats
      ax_o.len  = burst_len;
      ax_o.size = 3'(DataBytesLog);
    end else begin
      // One element per beat
      ax_o.len  = '0;
      ax_o.size = {1'b0, vew_q};
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    req.ready = 1'b0;
    case (state_q)
      IDLE: begin
        if (req.valid) begin
          // Empty operation is done at once
          if (req.len == '0) req.ready = 1'b1;
          else if (!req.is_load && st_pending_i) state_d = WAITING;
          else state_d = REQUESTING;
        end
      end
      WAITING: begin
        if (!st_pending_i) state_d = REQUESTING;
      end
      REQUESTING: begin
        if (issue && last_beat) begin
          req.ready = 1'b1;
          state_d   = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) state_q <= IDLE;
    else state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req.valid) begin
      addr_q     <= req.addr;
      len_q      <= req.len;
      stride_q   <= req.stride;
      vew_q      <= req.vew;
      is_load_q  <= req.is_load;
      is_burst_q <= req.is_burst;
      start_q    <= calc_start;
      end_q      <= calc_end;
      next_q     <= calc_next;
    end else if (issue) begin
      if (is_burst_q) begin
        // Move on to the next burst
        addr_q  <= next_q;
        len_q   <= len_rem;
        start_q <= calc_start;
        end_q   <= calc_end;
        next_q  <= calc_next;
      end else begin
        // Next strided element
        addr_q <= addr_q + stride_q;
        len_q  <= len_q - 1'b1;
      end
    end
  end

endmodule

// File: hdl/ax_cmd_fifo.sv
// Type-parameterized circular command queue toward the load/store units
`timescale 1ns/100ps

module ax_cmd_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     valid_o,
  output logic     full_o,
  output logic     empty_o
);
  import vaddr_cfg_pkg::*;

  // Storage
  payload_t                         mem_q [CmdQueueDepth];

  // Pointers and fill level
  logic [$clog2(CmdQueueDepth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(CmdQueueDepth):0]   count_q;

  logic                             do_push, do_pop;

  assign full_o  = (count_q == CmdQueueDepth);
  assign empty_o = (count_q == '0);
  assign valid_o = !empty_o;
  // Head entry
  assign data_o  = mem_q[rd_ptr_q];

  // Writes to a full queue and reads from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == CmdQueueDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == CmdQueueDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill level
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: hdl/vaddr_gen_top.sv
// Top level of the vector address generator with plain AR/AW and command queue ports
`timescale 1ns/100ps

module vaddr_gen_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Instruction request
  input  logic                                            req_valid_i,
  input  vaddr_types_pkg::vmem_op_e                       req_op_i,
  input  vaddr_types_pkg::addr_t                          req_addr_i,
  input  vaddr_types_pkg::len_t                           req_len_i,
  input  vaddr_types_pkg::addr_t                          req_stride_i,
  input  vaddr_types_pkg::vew_e                           req_vew_i,
  // Status
  output logic                                            ack_o,
  output logic                                            error_o,
  // Core
  input  logic                                            st_pending_i,
  // Read address channel
  output vaddr_types_pkg::addr_t                          ar_addr_o,
  output logic [$clog2(vaddr_cfg_pkg::MaxBurstBeats)-1:0] ar_len_o,
  output logic [2:0]                                      ar_size_o,
  output logic                                            ar_valid_o,
  input  logic                                            ar_ready_i,
  // Write address channel
  output vaddr_types_pkg::addr_t                          aw_addr_o,
  output logic [$clog2(vaddr_cfg_pkg::MaxBurstBeats)-1:0] aw_len_o,
  output logic [2:0]                                      aw_size_o,
  output logic                                            aw_valid_o,
  input  logic                                            aw_ready_i,
  // Command queue
  output vaddr_types_pkg::ax_cmd_t                        cmd_o,
  output logic                                            cmd_valid_o,
  input  logic                                            cmd_pop_i
);
  import vaddr_types_pkg::*;

  vaddr_req_if req_if ();

  // Splitter to queue
  ax_cmd_t ax_cmd;
  logic    ax_push;
  logic    q_full, q_empty;

  vinsn_accept u_accept (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_len_i    (req_len_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .ack_o        (ack_o),
    .error_o      (error_o),
    .req          (req_if.accept)
  );

  burst_splitter u_splitter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .st_pending_i     (st_pending_i),
    .ar_ready_i       (ar_ready_i),
    .aw_ready_i       (aw_ready_i),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (cmd_o.is_load),
    .ar_valid_o       (ar_valid_o),
    .aw_valid_o       (aw_valid_o),
    .ax_o             (ax_cmd),
    .push_o           (ax_push),
    .req              (req_if.split)
  );

  ax_cmd_fifo #(
    .payload_t (ax_cmd_t)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (ax_push),
    .data_i  (ax_cmd),
    .pop_i   (cmd_pop_i),
    .data_o  (cmd_o),
    .valid_o (cmd_valid_o),
    .full_o  (q_full),
    .empty_o (q_empty)
  );

  // Both channels carry the same request fields
  assign ar_addr_o = ax_cmd.addr;
  assign ar_len_o  = ax_cmd.len;
  assign ar_size_o = ax_cmd.size;
  assign aw_addr_o = ax_cmd.addr;
  assign aw_len_o  = ax_cmd.len;
  assign aw_size_o = ax_cmd.size;

endmodule

// File: bench/vaddr_gen_asserts.sv
// Concurrent assertions on the AR/AW outputs and status of the address generator, with bind
`timescale 1ns/100ps

module vaddr_gen_asserts (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            ar_valid_i,
  input  logic                                            aw_valid_i,
  input  logic                                            ack_i,
  input  logic                                            error_i,
  input  vaddr_types_pkg::addr_t                          ar_addr_i,
  input  vaddr_types_pkg::addr_t                          aw_addr_i,
  input  logic [$clog2(vaddr_cfg_pkg::MaxBurstBeats)-1:0] ar_len_i,
  input  logic [$clog2(vaddr_cfg_pkg::MaxBurstBeats)-1:0] aw_len_i,
  input  logic [2:0]                                      ar_size_i,
  input  logic [2:0]                                      aw_size_i,
  input  logic                                            is_burst_i
);
  import vaddr_cfg_pkg::*;

  // Number of failed assertions
  int unsigned         fail_count = 0;

  // Offset from the page start to one past the last burst byte
  logic [PageBits+1:0] ar_reach, aw_reach;

  assign ar_reach = ((ar_addr_i[PageBits-1:0] >> ar_size_i) << ar_size_i)
                  + ((ar_len_i + 1) << ar_size_i);
  assign aw_reach = ((aw_addr_i[PageBits-1:0] >> aw_size_i) << aw_size_i)
                  + ((aw_len_i + 1) << aw_size_i);

  ////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////

  // One address channel at a time
  a_one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_i && aw_valid_i))
    else begin
      fail_count++;
      $error("AR and AW valid together");
    end

  a_error_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_i |-> ack_i)
    else begin
      fail_count++;
      $error("Error without acknowledge");
    end

  // Bursts stay inside one 4 KiB page
  a_ar_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i |-> (ar_reach <= (1 << PageBits)))
    else begin
      fail_count++;
      $error("AR burst crosses a page");
    end

  a_aw_page: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i |-> (aw_reach <= (1 << PageBits)))
    else begin
      fail_count++;
      $error("AW burst crosses a page");
    end

  // Strided elements go out as single beats
  a_strided_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((ar_valid_i || aw_valid_i) && !is_burst_i) |-> ((ar_valid_i ? ar_len_i : aw_len_i) == '0))
    else begin
      fail_count++;
      $error("Strided request longer than one beat");
    end

endmodule

bind vaddr_gen_top vaddr_gen_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ar_valid_i (ar_valid_o),
  .aw_valid_i (aw_valid_o),
  .ack_i      (ack_o),
  .error_i    (error_o),
  .ar_addr_i  (ar_addr_o),
  .aw_addr_i  (aw_addr_o),
  .ar_len_i   (ar_len_o),
  .aw_len_i   (aw_len_o),
  .ar_size_i  (ar_size_o),
  .aw_size_i  (aw_size_o),
  .is_burst_i (req_if.is_burst)
);

// File: bench/vaddr_gen_tb.sv
// Testbench with clock, reset, reference model, compare tasks and directed tests
`timescale 1ns/100ps

module vaddr_gen_tb;
  import vaddr_cfg_pkg::*;
  import vaddr_types_pkg::*;

  // Longest test is a few hundred cycles even with random stalls
  localparam int unsigned TimeoutCycles = 4000;
  localparam int unsigned LenBits = $clog2(MaxBurstBeats);

  logic               clk_i, rst_ni;
  logic               req_valid_i, st_pending_i;
  vmem_op_e           req_op_i;
  addr_t              req_addr_i, req_stride_i;
  len_t               req_len_i;
  vew_e               req_vew_i;
  logic               ack_o, error_o;
  addr_t              ar_addr_o, aw_addr_o;
  logic [LenBits-1:0] ar_len_o, aw_len_o;
  logic [2:0]         ar_size_o, aw_size_o;
  logic               ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  ax_cmd_t            cmd_o;
  logic               cmd_valid_o, cmd_pop_i;

  // Expected and observed traffic of the running test
  ax_cmd_t            exp_ar[$], exp_aw[$], exp_cmd[$];
  ax_cmd_t            seen_ar[$], seen_aw[$], seen_cmd[$];

  int                 errors;
  int                 cycle_count;
  logic [15:0]        lfsr;
  // Stall controls changed only at the falling edge
  logic               stall_ready, stall_pop;

  vaddr_gen_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_len_i    (req_len_i),
    .req_stride_i (req_stride_i),
    .req_vew_i    (req_vew_i),
    .ack_o        (ack_o),
    .error_o      (error_o),
    .st_pending_i (st_pending_i),
    .ar_addr_o    (ar_addr_o),
    .ar_len_o     (ar_len_o),
    .ar_size_o    (ar_size_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .aw_addr_o    (aw_addr_o),
    .aw_len_o     (aw_len_o),
    .aw_size_o    (aw_size_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .cmd_o        (cmd_o),
    .cmd_valid_o  (cmd_valid_o),
    .cmd_pop_i    (cmd_pop_i)
  );

  ////////////////////////////////////////////////////////////
  // Clock, watchdog, background drivers and monitor
  ////////////////////////////////////////////////////////////

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic next_random_bit();
    lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    return lfsr[0];
  endfunction

  // Channel ready and queue pops driven 2 ns after the edge
  always @(posedge clk_i) begin
    #2;
    if (stall_ready) begin
      ar_ready_i = next_random_bit();
      aw_ready_i = next_random_bit();
    end else begin
      ar_ready_i = 1'b1;
      aw_ready_i = 1'b1;
    end
    cmd_pop_i = cmd_valid_o && !stall_pop;
  end

  // Valid only rises together with ready, so each valid cycle is a transfer
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o) begin
        seen_ar.push_back(ax_cmd_t'{addr: ar_addr_o, len: ar_len_o,
                                    size: ar_size_o, is_load: 1'b1});
      end
      if (aw_valid_o) begin
        seen_aw.push_back(ax_cmd_t'{addr: aw_addr_o, len: aw_len_o,
                                    size: aw_size_o, is_load: 1'b0});
      end
      if (cmd_valid_o && cmd_pop_i) seen_cmd.push_back(cmd_o);
      // Store ordering rule
      if (aw_valid_o && (st_pending_i || (cmd_valid_o && cmd_o.is_load))) begin
        $display("AW request issued while a load was queued or a scalar store pending, %0t",
                 $time);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  task automatic add_expected(ax_cmd_t c);
    exp_cmd.push_back(c);
    if (c.is_load) exp_ar.push_back(c);
    else exp_aw.push_back(c);
  endtask

  // Bursts end at the data end, the burst limit or the page end, whichever is first
  task automatic model_unit(addr_t addr, len_t len, vew_e vew, logic is_load);
    addr_t   cur, stop, last, page_end;
    ax_cmd_t c;
    cur  = addr & ~addr_t'(DataBytes - 1);
    last = ((addr + (addr_t'(len) << vew) - 1) & ~addr_t'(DataBytes - 1)) + DataBytes;
    while (cur < last) begin
      stop = last;
      if (stop - cur > MaxBurstBeats * DataBytes) stop = cur + MaxBurstBeats * DataBytes;
      page_end = ((cur >> PageBits) << PageBits) + (1 << PageBits);
      if (stop > page_end) stop = page_end;
      // First burst keeps the unaligned start
      c.addr    = (cur < addr) ? addr : cur;
      c.len     = LenBits'((stop - cur) / DataBytes - 1);
      c.size    = 3'(DataBytesLog);
      c.is_load = is_load;
      add_expected(c);
      cur = stop;
    end
  endtask

  // One beat of element size per element
  task automatic model_strided(addr_t addr, len_t len, addr_t stride, vew_e vew, logic is_load);
    ax_cmd_t c;
    for (int i = 0; i < len; i++) begin
      c.addr    = addr + addr_t'(i) * stride;
      c.len     = '0;
      c.size    = 3'(vew);
      c.is_load = is_load;
      add_expected(c);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  // Values shown as addr/len/size/load
  task automatic check_cmd(string name, ax_cmd_t exp, ax_cmd_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h/%0d/%0d/%b actual %h/%0d/%0d/%b",
               name, exp.addr, exp.len, exp.size, exp.is_load,
               act.addr, act.len, act.size, act.is_load);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_list(string name, ax_cmd_t exp[$], ax_cmd_t act[$]);
    int n;
    if (exp.size() != act.size()) begin
      $display("FAILED %s count: expected %0d actual %0d", name, exp.size(), act.size());
      errors++;
    end
    n = (exp.size() < act.size()) ? exp.size() : act.size();
    for (int i = 0; i < n; i++) check_cmd($sformatf("%s #%0d", name, i), exp[i], act[i]);
  endtask

  task automatic compare_results(string name);
    compare_list({name, " AR"}, exp_ar, seen_ar);
    compare_list({name, " AW"}, exp_aw, seen_aw);
    compare_list({name, " cmd"}, exp_cmd, seen_cmd);
  endtask

  ////////////////////////////////////////////////////////////
  // Request sequencing
  ////////////////////////////////////////////////////////////

  task automatic start_test();
    exp_ar.delete();
    exp_aw.delete();
    exp_cmd.delete();
    seen_ar.delete();
    seen_aw.delete();
    seen_cmd.delete();
  endtask

  // One-cycle request followed by a wait for the acknowledge
  task automatic send_request(vmem_op_e op, addr_t addr, len_t len, addr_t stride, vew_e vew,
                              output logic err);
    @(posedge clk_i);
    #2;
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_len_i    = len;
    req_stride_i = stride;
    req_vew_i    = vew;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    err = error_o;
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (cmd_valid_o) @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_flag("reset ack", 1'b0, ack_o);
    check_flag("reset error", 1'b0, error_o);
    check_flag("reset ar_valid", 1'b0, ar_valid_o);
    check_flag("reset aw_valid", 1'b0, aw_valid_o);
    check_flag("reset cmd_valid", 1'b0, cmd_valid_o);
  endtask

  task automatic test_page_cross();
    logic err;
    start_test();
    model_unit(32'h0000_0FF0, 16'd8, EW32, 1'b1);
    send_request(VLE, 32'h0000_0FF0, 16'd8, '0, EW32, err);
    wait_drain();
    check_flag("page_cross error", 1'b0, err);
    compare_results("page_cross");
  endtask

  task automatic test_long_store();
    logic err;
    start_test();
    model_unit(32'h0000_0000, 16'd600, EW64, 1'b0);
    send_request(VSE, 32'h0000_0000, 16'd600, '0, EW64, err);
    wait_drain();
    check_flag("long_store error", 1'b0, err);
    compare_results("long_store");
  endtask

  task automatic test_strided_load();
    logic err;
    start_test();
    model_strided(32'h0000_2000, 16'd5, 32'd40, EW16, 1'b1);
    send_request(VLSE, 32'h0000_2000, 16'd5, 32'd40, EW16, err);
    wait_drain();
    check_flag("strided_load error", 1'b0, err);
    compare_results("strided_load");
  endtask

  task automatic test_misaligned();
    logic err;
    start_test();
    send_request(VLE, 32'h0000_0102, 16'd4, '0, EW32, err);
    repeat (4) @(negedge clk_i);
    check_flag("misaligned error", 1'b1, err);
    compare_results("misaligned");
  endtask

  // Queued loads and a pending scalar store each hold back the following store on their own
  task automatic test_order_backpressure();
    logic err_ld, err_st;
    start_test();
    model_strided(32'h0000_5000, 16'd3, 32'd16, EW32, 1'b1);
    model_unit(32'h0000_6000, 16'd4, EW64, 1'b0);
    @(negedge clk_i);
    stall_pop   = 1'b1;
    stall_ready = 1'b1;
    send_request(VLSE, 32'h0000_5000, 16'd3, 32'd16, EW32, err_ld);
    @(posedge clk_i);
    #2;
    st_pending_i = 1'b1;
    fork
      send_request(VSE, 32'h0000_6000, 16'd4, '0, EW64, err_st);
      begin
        // Scalar store clears while the loads are still queued
        repeat (6) @(posedge clk_i);
        #2;
        st_pending_i = 1'b0;
        repeat (6) @(posedge clk_i);
        #2;
        st_pending_i = 1'b1;
        // Queue drains while a scalar store is pending again
        @(negedge clk_i);
        stall_pop = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        st_pending_i = 1'b0;
      end
    join
    wait_drain();
    stall_ready = 1'b0;
    check_flag("order load error", 1'b0, err_ld);
    check_flag("order store error", 1'b0, err_st);
    compare_results("order");
  endtask

  initial begin
    errors       = 0;
    cycle_count  = 0;
    lfsr         = 16'd1754;
    stall_ready  = 1'b0;
    stall_pop    = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = VLE;
    req_addr_i   = '0;
    req_len_i    = '0;
    req_stride_i = '0;
    req_vew_i    = EW8;
    st_pending_i = 1'b0;
    ar_ready_i   = 1'b1;
    aw_ready_i   = 1'b1;
    cmd_pop_i    = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset_state();
    test_page_cross();
    test_long_store();
    test_strided_load();
    test_misaligned();
    test_order_backpressure();
    repeat (4) @(negedge clk_i);
    $display("Run complete: %0d check errors, %0d assertion failures",
             errors, DUT.u_asserts.fail_count);
    if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: vaddr_gen.f
hdl/vaddr_cfg_pkg.sv
hdl/vaddr_types_pkg.sv
hdl/vaddr_req_if.sv
hdl/vinsn_accept.sv
hdl/burst_splitter.sv
hdl/ax_cmd_fifo.sv
hdl/vaddr_gen_top.sv
bench/vaddr_gen_asserts.sv
bench/vaddr_gen_tb.sv
